// ==== verilog/mips_pkg.sv ====
/*
 * MIPS32 shared definitions for the decode and execute slice
 * Word and register widths, opcode and function codes, ALU operations,
 * exception codes and the two views of an instruction word
 */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    // ************************************************
    // Opcode and function fields
    // ************************************************
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_SLT     = 6'h2a;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_RI   = 2'd1,    // Reserved instruction
        EXC_OV   = 2'd2     // Signed arithmetic overflow
    } exc_e;

    // ************************************************
    // Instruction word, read as R-type or I-type
    // ************************************************
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

endpackage

`default_nettype wire

// ==== verilog/reg_file.sv ====
/*
 * General purpose register file
 * 31 writable registers with register 0 fixed at zero, two
 * combinational read ports and a write port that reads through
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  mips_pkg::reg_addr_t ra1,
    input  wire  mips_pkg::reg_addr_t ra2,
    input  wire                       we,
    input  wire  mips_pkg::reg_addr_t wa,
    input  wire  mips_pkg::data_t     wd,
    output mips_pkg::data_t           rd1,
    output mips_pkg::data_t           rd2
);
    import mips_pkg::*;

    data_t regs [1:31];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is seen by the reader, so WB needs no forwarding path
    assign rd1 = (ra1 == '0) ? '0 : (we && (wa == ra1)) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && (wa == ra2)) ? wd : regs[ra2];

    a_zero_reg: assert property (@(posedge clk) disable iff (rst)
        ((ra1 == '0) |-> (rd1 == '0)) and ((ra2 == '0) |-> (rd2 == '0)));

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
/*
 * Instruction decode
 * Forms the ALU operation, operands, destination and early exception,
 * and holds back an instruction that reads the result still in EX
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire  mips_pkg::instr_u    instr,
    input  wire  mips_pkg::addr_t     instr_pc,
    input  wire                       instr_valid,
    input  wire                       flush,
    input  wire  mips_pkg::data_t     rd1,
    input  wire  mips_pkg::data_t     rd2,
    input  wire  mips_pkg::reg_addr_t ex_wraddr,
    input  wire                       ex_wreg,
    output mips_pkg::reg_addr_t       ra1,
    output mips_pkg::reg_addr_t       ra2,
    output logic                      stall,
    output logic                      bubble,
    output mips_pkg::addr_t           id_pc,
    output mips_pkg::alu_op_e         id_aluop,
    output mips_pkg::data_t           id_opr1,
    output mips_pkg::data_t           id_opr2,
    output mips_pkg::reg_addr_t       id_wraddr,
    output logic                      id_wreg,
    output mips_pkg::exc_e            id_excp
);
    import mips_pkg::*;

    logic  use_rs;
    logic  use_rt;
    logic  zero_ext;
    logic  hazard;
    data_t imm_sext;
    data_t imm_zext;

    assign ra1   = instr.r.rs;
    assign ra2   = instr.r.rt;
    assign id_pc = instr_pc;

    assign imm_sext = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign imm_zext = {16'h0000, instr.i.imm};

    always_comb begin
        id_aluop  = ALU_NOP;
        id_opr1   = rd1;
        id_opr2   = rd2;
        id_wraddr = instr.i.rt;     // I-type writes rt
        id_wreg   = 1'b0;
        id_excp   = EXC_RI;
        use_rs    = 1'b0;
        use_rt    = 1'b0;
        zero_ext  = 1'b0;
        case (instr.r.opcode)
            OP_SPECIAL: begin
                id_wraddr = instr.r.rd;
                use_rs    = 1'b1;
                use_rt    = 1'b1;
                case (instr.r.funct)
                    FN_ADD:  id_aluop = ALU_ADD;
                    FN_ADDU: id_aluop = ALU_ADDU;
                    FN_SUB:  id_aluop = ALU_SUB;
                    FN_AND:  id_aluop = ALU_AND;
                    FN_OR:   id_aluop = ALU_OR;
                    FN_XOR:  id_aluop = ALU_XOR;
                    FN_SLT:  id_aluop = ALU_SLT;
                    FN_SLL: begin
                        id_aluop = ALU_SLL;
                        id_opr1  = {27'd0, instr.r.shamt};
                        use_rs   = 1'b0;
                    end
                    default: ;
                endcase
            end
            OP_ADDI:  id_aluop = ALU_ADD;
            OP_ADDIU: id_aluop = ALU_ADDU;
            OP_SLTI:  id_aluop = ALU_SLT;
            OP_ANDI: begin
                id_aluop = ALU_AND;
                zero_ext = 1'b1;
            end
            OP_ORI: begin
                id_aluop = ALU_OR;
                zero_ext = 1'b1;
            end
            OP_XORI: begin
                id_aluop = ALU_XOR;
                zero_ext = 1'b1;
            end
            OP_LUI: begin
                id_aluop = ALU_LUI;
                zero_ext = 1'b1;
            end
            default: ;
        endcase

        if (instr.r.opcode != OP_SPECIAL) begin
            id_opr2 = zero_ext ? imm_zext : imm_sext;
            use_rs  = (id_aluop != ALU_LUI);
        end

        // A recognised encoding always leaves a non-NOP operation behind
        if (id_aluop != ALU_NOP) begin
            id_wreg = 1'b1;
            id_excp = EXC_NONE;
        end else begin
            use_rs = 1'b0;
            use_rt = 1'b0;
        end
    end

    assign hazard = ex_wreg && (ex_wraddr != '0)
                  && ((use_rs && (instr.r.rs == ex_wraddr))
                  ||  (use_rt && (instr.r.rt == ex_wraddr)));

    assign stall  = instr_valid && !flush && hazard;    // A flushed word may be dropped at once
    assign bubble = flush || stall || !instr_valid;

endmodule

`default_nettype wire

// ==== verilog/reg_id_ex.sv ====
/*
 * ID/EX pipeline register
 * Loads the decoded instruction, holds it on a stall and turns it
 * into a bubble on a flush
 */
`timescale 1ns/1ps
`default_nettype none

module reg_id_ex (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       stall,
    input  wire                       flush,
    input  wire  mips_pkg::addr_t     id_pc,
    input  wire  mips_pkg::alu_op_e   id_aluop,
    input  wire  mips_pkg::data_t     id_opr1,
    input  wire  mips_pkg::data_t     id_opr2,
    input  wire  mips_pkg::reg_addr_t id_wraddr,
    input  wire                       id_wreg,
    input  wire  mips_pkg::exc_e      id_excp,
    output mips_pkg::addr_t           ex_pc,
    output mips_pkg::alu_op_e         ex_aluop,
    output mips_pkg::data_t           ex_opr1,
    output mips_pkg::data_t           ex_opr2,
    output mips_pkg::reg_addr_t       ex_wraddr,
    output logic                      ex_wreg,
    output mips_pkg::exc_e            ex_excp
);
    import mips_pkg::*;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ex_pc     <= '0;
            ex_aluop  <= ALU_NOP;
            ex_opr1   <= '0;
            ex_opr2   <= '0;
            ex_wraddr <= '0;
            ex_wreg   <= 1'b0;
            ex_excp   <= EXC_NONE;
        end else if (flush) begin
            ex_pc     <= '0;
            ex_aluop  <= ALU_NOP;
            ex_opr1   <= '0;
            ex_opr2   <= '0;
            ex_wraddr <= '0;
            ex_wreg   <= 1'b0;
            ex_excp   <= EXC_NONE;
        end else if (!stall) begin
            ex_pc     <= id_pc;
            ex_aluop  <= id_aluop;
            ex_opr1   <= id_opr1;
            ex_opr2   <= id_opr2;
            ex_wraddr <= id_wraddr;
            ex_wreg   <= id_wreg;
            ex_excp   <= id_excp;
        end
        // Stall without flush keeps the current contents
    end

    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        flush |=> !ex_wreg);

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
/*
 * Execute stage
 * ALU with signed overflow detection, followed by the register that
 * holds the writeback record and any exception
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  mips_pkg::addr_t     ex_pc,
    input  wire  mips_pkg::alu_op_e   ex_aluop,
    input  wire  mips_pkg::data_t     ex_opr1,
    input  wire  mips_pkg::data_t     ex_opr2,
    input  wire  mips_pkg::reg_addr_t ex_wraddr,
    input  wire                       ex_wreg,
    input  wire  mips_pkg::exc_e      ex_excp,
    output logic                      wb_en,
    output mips_pkg::reg_addr_t       wb_addr,
    output mips_pkg::data_t           wb_data,
    output mips_pkg::exc_e            excp,
    output mips_pkg::addr_t           excp_pc
);
    import mips_pkg::*;

    data_t sum;
    data_t diff;
    data_t result;
    logic  overflow;
    exc_e  excp_next;

    assign sum  = ex_opr1 + ex_opr2;
    assign diff = ex_opr1 - ex_opr2;

    always_comb begin
        case (ex_aluop)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB:           result = diff;
            ALU_AND:           result = ex_opr1 & ex_opr2;
            ALU_OR:            result = ex_opr1 | ex_opr2;
            ALU_XOR:           result = ex_opr1 ^ ex_opr2;
            ALU_SLT:           result = {31'd0, $signed(ex_opr1) < $signed(ex_opr2)};
            ALU_SLL:           result = ex_opr2 << ex_opr1[4:0];
            ALU_LUI:           result = {ex_opr2[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // Overflow when the operand signs agree (add) or differ (sub) and the result sign flips
    always_comb begin
        case (ex_aluop)
            ALU_ADD: overflow = (ex_opr1[31] == ex_opr2[31]) && (sum[31] != ex_opr1[31]);
            ALU_SUB: overflow = (ex_opr1[31] != ex_opr2[31]) && (diff[31] != ex_opr1[31]);
            default: overflow = 1'b0;
        endcase
    end

    assign excp_next = (ex_excp != EXC_NONE) ? ex_excp : (overflow ? EXC_OV : EXC_NONE);

    // ************************************************
    // Writeback record
    // ************************************************
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_en   <= 1'b0;
            wb_addr <= '0;
            wb_data <= '0;
            excp    <= EXC_NONE;
            excp_pc <= '0;
        end else begin
            wb_en   <= ex_wreg && (excp_next == EXC_NONE);
            wb_addr <= ex_wraddr;
            wb_data <= result;
            excp    <= excp_next;
            excp_pc <= ex_pc;
        end
    end

    a_no_write_on_exc: assert property (@(posedge clk) disable iff (rst)
        wb_en |-> (excp == EXC_NONE));

endmodule

`default_nettype wire

// ==== verilog/mips_id_ex_core.sv ====
/*
 * Decode and execute slice of a MIPS32 integer pipeline
 * Register file, decoder, ID/EX register and execute stage
 */
`timescale 1ns/1ps
`default_nettype none

module mips_id_ex_core (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  mips_pkg::instr_u    instr,
    input  wire  mips_pkg::addr_t     instr_pc,
    input  wire                       instr_valid,
    input  wire                       flush,
    output logic                      stall,
    output logic                      wb_en,
    output mips_pkg::reg_addr_t       wb_addr,
    output mips_pkg::data_t           wb_data,
    output mips_pkg::exc_e            excp,
    output mips_pkg::addr_t           excp_pc
);
    import mips_pkg::*;

    reg_addr_t ra1, ra2;
    data_t     rd1, rd2;
    logic      bubble;

    addr_t     id_pc, ex_pc;
    alu_op_e   id_aluop, ex_aluop;
    data_t     id_opr1, ex_opr1;
    data_t     id_opr2, ex_opr2;
    reg_addr_t id_wraddr, ex_wraddr;
    logic      id_wreg, ex_wreg;
    exc_e      id_excp, ex_excp;

    reg_file u_reg_file (
        .clk (clk), .rst (rst),
        .ra1 (ra1), .ra2 (ra2),
        .we  (wb_en), .wa (wb_addr), .wd (wb_data),     // Written from the WB record
        .rd1 (rd1), .rd2 (rd2)
    );

    decode_stage u_decode (
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .flush       (flush),
        .rd1 (rd1), .rd2 (rd2),
        .ex_wraddr (ex_wraddr), .ex_wreg (ex_wreg),
        .ra1 (ra1), .ra2 (ra2),
        .stall (stall), .bubble (bubble),
        .id_pc (id_pc), .id_aluop (id_aluop),
        .id_opr1 (id_opr1), .id_opr2 (id_opr2),
        .id_wraddr (id_wraddr), .id_wreg (id_wreg), .id_excp (id_excp)
    );

    // Every stall also raises bubble, so a stalled word is never issued twice
    reg_id_ex u_reg_id_ex (
        .clk (clk), .rst (rst),
        .stall (stall), .flush (bubble),
        .id_pc (id_pc), .id_aluop (id_aluop),
        .id_opr1 (id_opr1), .id_opr2 (id_opr2),
        .id_wraddr (id_wraddr), .id_wreg (id_wreg), .id_excp (id_excp),
        .ex_pc (ex_pc), .ex_aluop (ex_aluop),
        .ex_opr1 (ex_opr1), .ex_opr2 (ex_opr2),
        .ex_wraddr (ex_wraddr), .ex_wreg (ex_wreg), .ex_excp (ex_excp)
    );

    execute_stage u_execute (
        .clk (clk), .rst (rst),
        .ex_pc (ex_pc), .ex_aluop (ex_aluop),
        .ex_opr1 (ex_opr1), .ex_opr2 (ex_opr2),
        .ex_wraddr (ex_wraddr), .ex_wreg (ex_wreg), .ex_excp (ex_excp),
        .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data),
        .excp (excp), .excp_pc (excp_pc)
    );

endmodule

`default_nettype wire

// ==== test/tb_mips_id_ex_core.sv ====
/*
 * Testbench for the MIPS32 decode and execute slice
 * Drives instruction words, predicts each writeback record with a
 * reference model and compares it against the DUT outputs in order
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_id_ex_core;
    import mips_pkg::*;

    typedef struct packed {
        logic      wen;
        reg_addr_t dst;
        data_t     data;
        exc_e      exc;
    } expect_t;

    typedef struct packed {
        logic [31:0] word;
        addr_t       pc;
    } issued_t;

    logic      clk = 1'b0;
    logic      rst;
    instr_u    instr;
    addr_t     instr_pc;
    logic      instr_valid;
    logic      flush;
    logic      stall;
    logic      wb_en;
    reg_addr_t wb_addr;
    data_t     wb_data;
    exc_e      excp;
    addr_t     excp_pc;

    issued_t     expq [$];
    data_t       model [32];
    issued_t     cur_rec;
    expect_t     cur_exp;
    logic [31:0] seed;
    addr_t       next_pc;
    int          stall_count;

    mips_id_ex_core uut (
        .clk (clk), .rst (rst),
        .instr (instr), .instr_pc (instr_pc),
        .instr_valid (instr_valid), .flush (flush),
        .stall (stall), .wb_en (wb_en), .wb_addr (wb_addr),
        .wb_data (wb_data), .excp (excp), .excp_pc (excp_pc)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'(1 + lcg_next() % 31);    // Never register 0
    endfunction

    function automatic logic [31:0] r_word(input logic [5:0] fn, input reg_addr_t rs,
                                           input reg_addr_t rt, input reg_addr_t rd,
                                           input logic [4:0] shamt);
        return {OP_SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input reg_addr_t rs,
                                           input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // ************************************************
    // Reference model of one instruction
    // ************************************************
    function automatic expect_t ref_result(input logic [31:0] word, input data_t regs [32]);
        expect_t     e;
        data_t       a;
        data_t       b;
        data_t       sx;
        data_t       zx;
        logic [32:0] wide;
        a      = regs[word[25:21]];
        b      = regs[word[20:16]];
        sx     = {{16{word[15]}}, word[15:0]};
        zx     = {16'h0000, word[15:0]};
        wide   = '0;
        e.wen  = 1'b1;
        e.exc  = EXC_NONE;
        e.data = '0;
        e.dst  = word[20:16];
        if (word[31:26] == OP_SPECIAL) begin
            e.dst = word[15:11];    // R-type writes rd
            case (word[5:0])
                FN_ADD: begin
                    wide   = {a[31], a} + {b[31], b};
                    e.data = wide[31:0];
                    e.exc  = (wide[32] != wide[31]) ? EXC_OV : EXC_NONE;
                end
                FN_ADDU: e.data = a + b;
                FN_SUB: begin
                    wide   = {a[31], a} - {b[31], b};
                    e.data = wide[31:0];
                    e.exc  = (wide[32] != wide[31]) ? EXC_OV : EXC_NONE;
                end
                FN_AND:  e.data = a & b;
                FN_OR:   e.data = a | b;
                FN_XOR:  e.data = a ^ b;
                FN_SLT:  e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  e.data = b << word[10:6];
                default: e.exc = EXC_RI;
            endcase
        end else begin
            case (word[31:26])
                OP_ADDI: begin
                    wide   = {a[31], a} + {sx[31], sx};
                    e.data = wide[31:0];
                    e.exc  = (wide[32] != wide[31]) ? EXC_OV : EXC_NONE;
                end
                OP_ADDIU: e.data = a + sx;
                OP_SLTI:  e.data = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                OP_ANDI:  e.data = a & zx;
                OP_ORI:   e.data = a | zx;
                OP_XORI:  e.data = a ^ zx;
                OP_LUI:   e.data = {word[15:0], 16'h0000};
                default:  e.exc = EXC_RI;
            endcase
        end
        if (e.exc != EXC_NONE) begin
            e.wen = 1'b0;
        end
        return e;
    endfunction

    // Presents one word and returns after the edge that takes it
    task automatic issue(input logic [31:0] word, input logic flush_it);
        int waited;
        instr       = word;
        instr_pc    = next_pc;
        instr_valid = 1'b1;
        flush       = flush_it;
        waited      = 0;
        @(negedge clk);
        while (stall) begin
            stall_count++;
            waited++;
            if (waited > 8) begin
                report_failure("stall stayed high for more than 8 cycles");
            end
            @(negedge clk);
        end
        @(posedge clk);
        if (!flush_it) begin
            expq.push_back('{word: word, pc: next_pc});
        end
        next_pc = next_pc + 32'd4;
        #1;
        instr_valid = 1'b0;
        flush       = 1'b0;
    endtask

    // ************************************************
    // Compare process
    // ************************************************
    always @(negedge clk) begin
        if (!rst && (wb_en || (excp != EXC_NONE))) begin
            assert (expq.size() > 0) else
                report_failure("a writeback record appeared with no instruction outstanding");
            cur_rec = expq.pop_front();
            cur_exp = ref_result(cur_rec.word, model);
            assert (wb_en == cur_exp.wen) else
                report_failure($sformatf("ERR wb_en: got %h, expected %h", wb_en, cur_exp.wen));
            assert (excp == cur_exp.exc) else
                report_failure($sformatf("ERR excp: got %h, expected %h", excp, cur_exp.exc));
            assert (excp_pc == cur_rec.pc) else
                report_failure($sformatf("ERR excp_pc: got %h, expected %h",
                                         excp_pc, cur_rec.pc));
            if (cur_exp.wen) begin
                assert (wb_addr == cur_exp.dst) else
                    report_failure($sformatf("ERR wb_addr: got %h, expected %h",
                                             wb_addr, cur_exp.dst));
                assert (wb_data == cur_exp.data) else
                    report_failure($sformatf("ERR wb_data: got %h, expected %h",
                                             wb_data, cur_exp.data));
                if (cur_exp.dst != '0) begin
                    model[cur_exp.dst] = cur_exp.data;
                end
            end
        end
    end

    initial begin
        logic [5:0] fns [8];
        logic [5:0] ops [7];
        int         waited;
        fns = '{FN_ADD, FN_ADDU, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL};
        ops = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        rst         = 1'b1;
        instr       = '0;
        instr_pc    = '0;
        instr_valid = 1'b0;
        flush       = 1'b0;
        seed        = 32'hfe42_baf7;
        next_pc     = 32'h0000_1000;
        stall_count = 0;
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        // Fill registers with LUI then a dependent ORI, which also stalls
        for (int r = 1; r < 32; r++) begin
            issue(i_word(OP_LUI, 5'd0, reg_addr_t'(r), 16'(lcg_next())), 1'b0);
            issue(i_word(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), 16'(lcg_next())), 1'b0);
        end
        for (int n = 0; n < 40; n++) begin
            issue(r_word(fns[3'(lcg_next() % 8)], pick_reg(), pick_reg(), pick_reg(),
                         5'(lcg_next())), 1'b0);
        end
        for (int n = 0; n < 40; n++) begin
            issue(i_word(ops[3'(lcg_next() % 7)], pick_reg(), pick_reg(),
                         16'(lcg_next())), 1'b0);
        end

        // Overflow and reserved encodings, with later reads of r3
        issue(i_word(OP_LUI, 5'd0, 5'd1, 16'h7fff), 1'b0);
        issue(i_word(OP_ORI, 5'd1, 5'd1, 16'hffff), 1'b0);
        issue(i_word(OP_ORI, 5'd0, 5'd2, 16'h0001), 1'b0);
        issue(i_word(OP_LUI, 5'd0, 5'd5, 16'h8000), 1'b0);
        issue(r_word(FN_ADD, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0);
        issue(r_word(FN_OR, 5'd3, 5'd0, 5'd4, 5'd0), 1'b0);
        issue(r_word(FN_SUB, 5'd5, 5'd2, 5'd3, 5'd0), 1'b0);
        issue(i_word(OP_ADDI, 5'd1, 5'd3, 16'h0001), 1'b0);
        issue(i_word(6'h3f, 5'd1, 5'd3, 16'h1234), 1'b0);
        issue(r_word(6'h18, 5'd1, 5'd2, 5'd3, 5'd0), 1'b0);
        issue(r_word(FN_OR, 5'd3, 5'd0, 5'd6, 5'd0), 1'b0);

        // A flushed word leaves r7 alone
        issue(i_word(OP_ORI, 5'd0, 5'd7, 16'hbeef), 1'b1);
        issue(r_word(FN_OR, 5'd7, 5'd0, 5'd8, 5'd0), 1'b0);

        // Register 0 stays zero after writes
        issue(i_word(OP_ADDIU, 5'd0, 5'd0, 16'h1234), 1'b0);
        issue(r_word(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0), 1'b0);
        issue(r_word(FN_OR, 5'd0, 5'd0, 5'd9, 5'd0), 1'b0);
        issue(i_word(OP_ORI, 5'd0, 5'd10, 16'h0000), 1'b0);

        waited = 0;
        while (expq.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                report_failure("pipeline did not drain within 20 cycles");
            end
        end
        repeat (4) @(posedge clk);     // Room for any stray record to show up

        if (stall_count == 0) begin
            report_failure("stall never rose for a dependent instruction");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== mips_id_ex_core.f ====
verilog/mips_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/reg_id_ex.sv
verilog/execute_stage.sv
verilog/mips_id_ex_core.sv
test/tb_mips_id_ex_core.sv

// ==== Bender.yml ====
package:
  name: mips_id_ex_core

sources:
  - verilog/mips_pkg.sv
  - verilog/reg_file.sv
  - verilog/decode_stage.sv
  - verilog/reg_id_ex.sv
  - verilog/execute_stage.sv
  - verilog/mips_id_ex_core.sv
  - target: test
    files:
      - test/tb_mips_id_ex_core.sv
